//--- fifo_params.svh
// fifo geometry and flag thresholds, included by the package and any rtl needing raw sizes
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// ram address width, depth is 2**FIFO_ADDR_W
`define FIFO_ADDR_W 4

// width of one stored word
`define FIFO_DATA_W 8

// almost_full set when level is at or above this
`define FIFO_ALMOST_FULL 12

// almost_empty set when level is at or below this
`define FIFO_ALMOST_EMPTY 3

`endif

//--- fifo_pkg.sv
// vector types shared by the fifo rtl and its testbench, referenced by scoped name
`default_nettype none

`include "fifo_params.svh"

package fifo_pkg;

    // ram word address, one entry per fifo slot
    typedef logic [`FIFO_ADDR_W-1:0] addr_t;

    // binary pointer with one extra wrap bit
    // msb toggles each time the pointer passes the top of the ram
    typedef logic [`FIFO_ADDR_W:0] ptr_t;

    // one stored data word
    typedef logic [`FIFO_DATA_W-1:0] data_t;

    // occupancy 0 .. depth, hence the extra bit
    typedef logic [`FIFO_ADDR_W:0] level_t;

endpackage

`default_nettype wire

//--- fifo_mem_if.sv
// ram control bundle between the pointer controller and the dual-port ram
`default_nettype none

interface fifo_mem_if;

    // ******************************************************************
    // write side
    // ******************************************************************
    logic            we;     // write strobe, already gated by wfull
    fifo_pkg::addr_t waddr;  // write slot

    // ******************************************************************
    // read side
    // ******************************************************************
    logic            re;     // read strobe, already gated by rempty
    fifo_pkg::addr_t raddr;  // read slot

    // controller drives everything
    modport ctrl (
        output we,
        output waddr,
        output re,
        output raddr
    );

    // ram only listens
    modport mem (
        input we,
        input waddr,
        input re,
        input raddr
    );

endinterface

`default_nettype wire

//--- fifo_ptr_ctrl.sv
// single-clock fifo pointer and flag controller, drives ram controls and status flags
`default_nettype none

`include "fifo_params.svh"

module fifo_ptr_ctrl (
    input  logic             rclk,          // fifo clock
    input  logic             rrst,          // async reset, active high
    input  logic             w_en,          // write strobe from user
    input  logic             r_en,          // read strobe from user
    fifo_mem_if.ctrl         mem,           // ram write/read controls
    output logic             wfull,         // registered full flag
    output logic             rempty,        // registered empty flag
    output logic             almost_full,   // level at or above threshold
    output logic             almost_empty,  // level at or below threshold
    output fifo_pkg::level_t level          // registered occupancy
);

    // thresholds sized to the level vector
    localparam fifo_pkg::level_t af_level = fifo_pkg::level_t'(`FIFO_ALMOST_FULL);
    localparam fifo_pkg::level_t ae_level = fifo_pkg::level_t'(`FIFO_ALMOST_EMPTY);

    // ******************************************************************
    // declarations
    // ******************************************************************
    logic             wr_acc;       // write accepted this cycle
    logic             rd_acc;       // read accepted this cycle

    fifo_pkg::ptr_t   wptr;         // current write pointer
    fifo_pkg::ptr_t   wptr_next;    // write pointer after this edge
    fifo_pkg::ptr_t   rptr;         // current read pointer
    fifo_pkg::ptr_t   rptr_next;    // read pointer after this edge

    logic             wfull_next;   // full as seen from next pointers
    logic             rempty_next;  // empty as seen from next pointers
    fifo_pkg::level_t level_next;   // occupancy from next pointers

    // ******************************************************************
    // accept logic
    // ******************************************************************
    // strobes against a set flag are simply dropped
    // a write while full stays dropped even with a read in the same cycle
    assign wr_acc = w_en & ~wfull;
    assign rd_acc = r_en & ~rempty;

    // ******************************************************************
    // write pointer
    // ******************************************************************
    always_comb
    begin
        if (wr_acc)
            wptr_next = wptr + fifo_pkg::ptr_t'(1);  // wraps through the msb
        else
            wptr_next = wptr;
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            wptr <= '0;
        else
            wptr <= wptr_next;
    end

    // ******************************************************************
    // read pointer
    // ******************************************************************
    always_comb
    begin
        if (rd_acc)
            rptr_next = rptr + fifo_pkg::ptr_t'(1);
        else
            rptr_next = rptr;
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            rptr <= '0;
        else
            rptr <= rptr_next;
    end

    // ******************************************************************
    // full and empty
    // ******************************************************************
    // full when wrap bits differ and slot bits match
    assign wfull_next = (wptr_next[`FIFO_ADDR_W] != rptr_next[`FIFO_ADDR_W])
                     && (wptr_next[`FIFO_ADDR_W-1:0] == rptr_next[`FIFO_ADDR_W-1:0]);

    // empty when the pointers match exactly
    assign rempty_next = (wptr_next == rptr_next);

    // both flags registered from the next pointers
    // so they line up with the pointer update
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wfull  <= 1'b0;
            rempty <= 1'b1;  // nothing stored after reset
        end
        else
        begin
            wfull  <= wfull_next;
            rempty <= rempty_next;
        end
    end

    // ******************************************************************
    // fill level
    // ******************************************************************
    // modular difference of the wide pointers
    // gives 0 .. depth without a case split on the wrap bits
    assign level_next = wptr_next - rptr_next;

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            level <= '0;
        else
            level <= level_next;
    end

    // ******************************************************************
    // almost flags
    // ******************************************************************
    // plain compares on the registered level
    assign almost_full  = (level >= af_level);
    assign almost_empty = (level <= ae_level);  // also high right after reset

    // ******************************************************************
    // ram controls
    // ******************************************************************
    assign mem.we    = wr_acc;                     // gated write strobe
    assign mem.waddr = wptr[`FIFO_ADDR_W-1:0];     // drop wrap bit
    assign mem.re    = rd_acc;                     // gated read strobe
    assign mem.raddr = rptr[`FIFO_ADDR_W-1:0];

endmodule

`default_nettype wire

//--- fifo_dpram.sv
// one-write one-read ram for the fifo, read data registered on each accepted read
`default_nettype none

`include "fifo_params.svh"

module fifo_dpram (
    input  logic            rclk,   // fifo clock
    input  logic            rrst,   // async reset, clears the read register only
    fifo_mem_if.mem         mem,    // gated strobes and addresses
    input  fifo_pkg::data_t wdata,  // word to store
    output fifo_pkg::data_t rdata   // oldest word after a read
);

    localparam int unsigned depth = 1 << `FIFO_ADDR_W;

    // ******************************************************************
    // storage
    // ******************************************************************
    fifo_pkg::data_t ram [0:depth-1];  // no reset on the array

    // write port
    always_ff @(posedge rclk)
    begin
        if (mem.we)
            ram[mem.waddr] <= wdata;
    end

    // ******************************************************************
    // read port
    // ******************************************************************
    // same slot is never written and read in one cycle
    // the fifo is then either full or empty and one strobe is gated off
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            rdata <= '0;
        else if (mem.re)
            rdata <= ram[mem.raddr];  // holds until the next accepted read
    end

endmodule

`default_nettype wire

//--- fifo_top.sv
// synchronous fifo top level, plain user ports around the controller and ram
`default_nettype none

module fifo_top (
    // clock and reset
    input  logic             rclk,          // single fifo clock
    input  logic             rrst,          // async reset, active high

    // write side
    input  logic             w_en,          // write strobe
    input  fifo_pkg::data_t  wdata,         // word to push

    // read side
    input  logic             r_en,          // read strobe
    output fifo_pkg::data_t  rdata,         // popped word, valid after the read edge

    // status
    output logic             wfull,         // no room for another write
    output logic             rempty,        // nothing to read
    output logic             almost_full,   // level at or above high mark
    output logic             almost_empty,  // level at or below low mark
    output fifo_pkg::level_t level          // words currently stored
);

    // ******************************************************************
    // ram control bundle
    // ******************************************************************
    fifo_mem_if u_mem_if ();  // we, waddr, re, raddr

    // ******************************************************************
    // pointer and flag controller
    // ******************************************************************
    // gates the strobes, steps the pointers
    // and registers all status outputs
    fifo_ptr_ctrl u_fifo_ptr_ctrl (
        .rclk         (rclk),
        .rrst         (rrst),
        .w_en         (w_en),
        .r_en         (r_en),
        .mem          (u_mem_if.ctrl),
        .wfull        (wfull),
        .rempty       (rempty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .level        (level)
    );

    // ******************************************************************
    // data storage
    // ******************************************************************
    // data path bypasses the controller entirely
    fifo_dpram u_fifo_dpram (
        .rclk  (rclk),
        .rrst  (rrst),
        .mem   (u_mem_if.mem),
        .wdata (wdata),  // straight from the user port
        .rdata (rdata)   // straight to the user port
    );

endmodule

`default_nettype wire

//--- fifo_sva.sv
// concurrent fifo checks against a shadow count, bound into fifo_top for simulation
`default_nettype none

`include "fifo_params.svh"

module fifo_sva (
    input wire logic             rclk,
    input wire logic             rrst,
    input wire logic             w_en,
    input wire logic             r_en,
    input wire fifo_pkg::data_t  rdata,
    input wire logic             wfull,
    input wire logic             rempty,
    input wire logic             almost_full,
    input wire logic             almost_empty,
    input wire fifo_pkg::level_t level
);

    localparam fifo_pkg::level_t depth   = fifo_pkg::level_t'(1 << `FIFO_ADDR_W);
    localparam fifo_pkg::level_t af_mark = fifo_pkg::level_t'(`FIFO_ALMOST_FULL);
    localparam fifo_pkg::level_t ae_mark = fifo_pkg::level_t'(`FIFO_ALMOST_EMPTY);

    // ******************************************************************
    // shadow count, accepts judged from the count alone
    // ******************************************************************
    fifo_pkg::level_t count;
    logic             w_acc;  // room left per shadow
    logic             r_acc;  // something stored per shadow

    assign w_acc = w_en && (count != depth);
    assign r_acc = r_en && (count != '0);

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
            count <= '0;
        else if (w_acc && !r_acc)
            count <= count + fifo_pkg::level_t'(1);
        else if (r_acc && !w_acc)
            count <= count - fifo_pkg::level_t'(1);
    end

    // ******************************************************************
    // reset values, during reset and at the first edge after it
    // ******************************************************************
    a_reset_state: assert property (@(posedge rclk) (rrst || $past(rrst)) |->
        (rempty && almost_empty && !wfull && !almost_full && level == '0))
        else $error("status outputs not at reset values");

    // level and flags follow the shadow count every cycle
    a_level: assert property (@(posedge rclk) disable iff (rrst) level == count)
        else $error("level differs from shadow count");
    a_full: assert property (@(posedge rclk) disable iff (rrst) wfull == (count == depth))
        else $error("wfull differs from shadow count");
    a_empty: assert property (@(posedge rclk) disable iff (rrst) rempty == (count == '0))
        else $error("rempty differs from shadow count");
    a_almost_full: assert property (@(posedge rclk) disable iff (rrst)
        almost_full == (count >= af_mark))
        else $error("almost_full threshold wrong");
    a_almost_empty: assert property (@(posedge rclk) disable iff (rrst)
        almost_empty == (count <= ae_mark))
        else $error("almost_empty threshold wrong");

    // ******************************************************************
    // blocked strobes and paired strobes
    // ******************************************************************
    a_full_write: assert property (@(posedge rclk) disable iff (rrst)
        (wfull && w_en && !r_en) |=> level == $past(level))
        else $error("write while full changed level");
    a_full_pair: assert property (@(posedge rclk) disable iff (rrst)
        (wfull && w_en && r_en) |=> level == $past(level) - fifo_pkg::level_t'(1))
        else $error("write with read while full not dropped");
    a_empty_read: assert property (@(posedge rclk) disable iff (rrst)
        (rempty && r_en) |=> rdata == $past(rdata))
        else $error("read while empty changed rdata");
    a_empty_level: assert property (@(posedge rclk) disable iff (rrst)
        (rempty && r_en && !w_en) |=> level == '0)
        else $error("read while empty changed level");
    a_pair_level: assert property (@(posedge rclk) disable iff (rrst)
        (!wfull && !rempty && w_en && r_en) |=> level == $past(level))
        else $error("paired read and write changed level");

endmodule

// attach to every fifo_top instance
bind fifo_top fifo_sva u_fifo_sva (
    .rclk         (rclk),
    .rrst         (rrst),
    .w_en         (w_en),
    .r_en         (r_en),
    .rdata        (rdata),
    .wfull        (wfull),
    .rempty       (rempty),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .level        (level)
);

`default_nettype wire

//--- tb_fifo.sv
// top testbench for the synchronous fifo, phased stimulus with a queue model on rdata
`default_nettype none

`include "fifo_params.svh"

module tb_fifo;

    localparam int depth        = 1 << `FIFO_ADDR_W;
    localparam int phase_cycles = 40;  // budget per phase
    localparam int num_phases   = 6;
    localparam int reset_cycles = 5;

    // ******************************************************************
    // dut signals
    // ******************************************************************
    logic             rclk;
    logic             rrst;
    logic             w_en;
    logic             r_en;
    fifo_pkg::data_t  wdata;
    fifo_pkg::data_t  rdata;
    logic             wfull;
    logic             rempty;
    logic             almost_full;
    logic             almost_empty;
    fifo_pkg::level_t level;

    // reference model
    fifo_pkg::data_t  model_q [$];  // accepted words, oldest first
    fifo_pkg::data_t  expected;     // word due on rdata
    logic             check_due;    // read accepted at last edge
    integer           seed;

    fifo_top u_fifo_top (
        .rclk         (rclk),
        .rrst         (rrst),
        .w_en         (w_en),
        .wdata        (wdata),
        .r_en         (r_en),
        .rdata        (rdata),
        .wfull        (wfull),
        .rempty       (rempty),
        .almost_full  (almost_full),
        .almost_empty (almost_empty),
        .level        (level)
    );

    always #2 rclk = ~rclk;  // period 4

    // one cycle, driven on the falling edge
    task automatic drive_cycle(input logic do_write, input logic do_read);
        fifo_pkg::data_t word;
        logic            w_ok;
        logic            r_ok;
        @(negedge rclk);
        // rdata settled since the last rising edge
        if (check_due && rdata !== expected)
        begin
            $display("CHECK FAILED at time %0t: rdata expected %h actual %h",
                     $time, expected, rdata);
            $display("TEST FAILED");
            $fatal(1, "rdata out of write order");
        end
        word  = fifo_pkg::data_t'($random(seed));
        w_ok  = do_write && (model_q.size() < depth);  // dropped when full
        r_ok  = do_read && (model_q.size() > 0);       // dropped when empty
        w_en  = do_write;
        r_en  = do_read;
        wdata = word;
        if (w_ok)
            model_q.push_back(word);
        check_due = r_ok;
        if (r_ok)
            expected = model_q.pop_front();
    endtask

    task automatic push_words(input int n);
        repeat (n) drive_cycle(1'b1, 1'b0);
    endtask

    task automatic pop_words(input int n);
        repeat (n) drive_cycle(1'b0, 1'b1);
    endtask

    task automatic push_pop(input int n);
        repeat (n) drive_cycle(1'b1, 1'b1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) drive_cycle(1'b0, 1'b0);
    endtask

    // ******************************************************************
    // stimulus phases
    // ******************************************************************
    initial
    begin
        seed      = 32'h741fa474;
        rclk      = 1'b0;
        rrst      = 1'b1;
        w_en      = 1'b0;
        r_en      = 1'b0;
        wdata     = '0;
        check_due = 1'b0;
        expected  = '0;
        repeat (reset_cycles) @(negedge rclk);
        rrst = 1'b0;
        idle_cycles(2);         // flags still at reset values here
        push_words(6);          // ordering
        pop_words(6);
        idle_cycles(2);
        push_words(depth);      // fill to full
        push_words(3);          // dropped
        push_pop(1);            // write dropped, read taken
        push_words(1);
        idle_cycles(2);
        pop_words(depth);       // drain
        pop_words(3);           // reads on empty
        idle_cycles(2);
        push_words(13);         // crosses both marks going up
        pop_words(13);          // and coming down
        idle_cycles(2);
        push_words(8);          // paired strobes mid-range
        push_pop(10);
        pop_words(8);
        idle_cycles(2);
        $display("TEST PASSED");
        $finish;
    end

    // watchdog
    initial
    begin
        #((reset_cycles + phase_cycles * num_phases) * 4);
        $display("timeout: stimulus did not finish within %0d cycles",
                 reset_cycles + phase_cycles * num_phases);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+.
fifo_pkg.sv
fifo_mem_if.sv
fifo_ptr_ctrl.sv
fifo_dpram.sv
fifo_top.sv
fifo_sva.sv
tb_fifo.sv

//--- Makefile
# Verilator build and run for the synchronous FIFO testbench

SRCS := $(filter-out +%,$(shell cat all.f)) fifo_params.svh

.PHONY: all run clean

all: obj_dir/Vtb_fifo

# rebuilt only when a source, the header or the file list changes
obj_dir/Vtb_fifo: all.f $(SRCS)
	verilator --binary --assert --top-module tb_fifo -Mdir obj_dir -f all.f

# exit status of the binary is the pass or fail result
run: obj_dir/Vtb_fifo
	./obj_dir/Vtb_fifo

clean:
	rm -rf obj_dir
